// File: source/huff_settings.svh
`ifndef HUFF_SETTINGS_SVH
`define HUFF_SETTINGS_SVH

// alphabet is the ten decimal digits
`define HUFF_NUM_SYM   10
`define HUFF_SYM_W     4                       // digit index width
`define HUFF_BLOCK_LEN 256                     // symbols per block

// 256 equal symbols must still fit without wrapping
`define HUFF_CNT_W     9
`define HUFF_CNT_MAX   {`HUFF_CNT_W{1'b1}}     // retired slot marker

`define HUFF_CODE_W    9                       // deepest degenerate tree
`define HUFF_LEN_W     4
`define HUFF_ROUNDS    9                       // ten leaves need nine merges

`endif

// File: source/huff_pkg.sv
package huff_pkg;

  `include "huff_settings.svh"

  typedef logic [`HUFF_SYM_W-1:0] sym_t;            // digit index
  typedef logic [`HUFF_CNT_W-1:0] count_t;          // occurrence count
  typedef count_t [`HUFF_NUM_SYM-1:0] count_vec_t;  // one count per digit

  typedef logic [`HUFF_NUM_SYM-1:0] sym_mask_t;     // digits inside a subtree

  typedef struct packed {
    logic [`HUFF_CODE_W-1:0] code;                  // right aligned, msb sent first
    logic [`HUFF_LEN_W-1:0]  len;
  } code_entry_t;

  typedef code_entry_t [`HUFF_NUM_SYM-1:0] code_table_t;

  // result of one selector pass
  typedef struct packed {
    sym_t sym_a;                                    // smallest count
    sym_t sym_b;                                    // second smallest
  } merge_pair_t;

  // one-hot round sequence, sel steps run lsb first
  typedef struct packed {
    logic                     encode;
    logic                     merge;
    logic [`HUFF_NUM_SYM-1:0] sel;
  } step_t;

  typedef enum logic [1:0] {
    ph_idle,
    ph_collect,
    ph_build,
    ph_emit
  } ctrl_phase_t;

endpackage

// File: source/huff_control.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module huff_control
  import huff_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  sym_req,
  input  sym_t  sym,
  output logic  sym_ack,
  output logic  count_inc,
  output sym_t  count_sym,
  output logic  clear,
  output step_t step,
  output logic  emit_go,
  input  logic  table_done
);

  ctrl_phase_t             phase;
  logic [`HUFF_CNT_W-1:0]  blk_cnt;   // symbols acknowledged so far
  logic [`HUFF_LEN_W-1:0]  round;     // merge round 0..8

  assign clear     = (phase == ph_idle);                      // one cycle before collect
  assign count_inc = (phase == ph_collect) && sym_req && !sym_ack;  // ack rising edge
  assign count_sym = sym;                                     // stable while req high

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      phase   <= ph_idle;
      sym_ack <= 1'b0;
      blk_cnt <= '0;
      round   <= '0;
      step    <= '0;
      emit_go <= 1'b0;
    end
    else
    begin
      emit_go <= 1'b0;
      if (count_inc)
        sym_ack <= 1'b1;
      else if (!sym_req)
        sym_ack <= 1'b0;                                      // falls in any phase
      case (phase)
        ph_idle:
          phase <= ph_collect;
        ph_collect:
          if (count_inc)
          begin
            if (blk_cnt == `HUFF_BLOCK_LEN - 1)
            begin
              blk_cnt <= '0;
              phase   <= ph_build;                            // input closed from here
            end
            else
              blk_cnt <= blk_cnt + 1'b1;
          end
        ph_build:
          if (step == '0)
            step <= {2'b00, 10'd1};                           // entry cycle, first sel step
          else if (step.encode)
          begin
            if (round == `HUFF_ROUNDS - 1)
            begin
              round   <= '0;
              step    <= '0;
              emit_go <= 1'b1;                                // codes settle this edge
              phase   <= ph_emit;
            end
            else
            begin
              round <= round + 1'b1;
              step  <= {2'b00, 10'd1};
            end
          end
          else
            step <= {step.merge, step.sel, 1'b0};             // walk sel, merge, encode
        ph_emit:
          if (table_done)
            phase <= ph_idle;                                 // reopen input
        default:
          phase <= ph_idle;
      endcase
    end
  end

endmodule

// File: source/symbol_counter.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module symbol_counter
  import huff_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        clear,
  input  logic        count_inc,
  input  sym_t        count_sym,
  input  logic        merge,
  input  merge_pair_t pair,
  output count_vec_t  counts
);

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      counts <= '0;
    else if (clear)
      counts <= '0;                                           // fresh block
    else if (count_inc)
    begin
      if (count_sym < `HUFF_NUM_SYM)                          // non-digits are dropped
        counts[count_sym] <= counts[count_sym] + 1'b1;
    end
    else if (merge)
    begin
      // b absorbs a, a leaves the search
      counts[pair.sym_b] <= counts[pair.sym_a] + counts[pair.sym_b];
      counts[pair.sym_a] <= `HUFF_CNT_MAX;
    end
  end

endmodule

// File: source/min_pair_select.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module min_pair_select
  import huff_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  step_t       step,
  input  count_vec_t  counts,
  output merge_pair_t pair
);

  count_vec_t snap;                      // counts frozen for one tournament
  count_t     tmp_cnt [4];               // survivors between steps
  sym_t       tmp_sym [4];
  count_t     l_cnt [4];                 // left side, lower indices
  count_t     r_cnt [4];                 // right side, higher indices
  sym_t       l_sym [4];
  sym_t       r_sym [4];
  count_t     w_cnt [4];
  sym_t       w_sym [4];
  logic       ph_a;                      // four leaf pairs
  logic       ph_b;                      // two semifinals
  logic       ph_c;                      // final of 0..7 plus pair 8/9
  logic       ph_d;                      // overall winner

  assign ph_a = step.sel[1] | step.sel[6];
  assign ph_b = step.sel[2] | step.sel[7];
  assign ph_c = step.sel[3] | step.sel[8];
  assign ph_d = step.sel[4] | step.sel[9];

  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      l_cnt[k] = snap[2*k];
      l_sym[k] = sym_t'(2*k);
      r_cnt[k] = snap[2*k+1];
      r_sym[k] = sym_t'(2*k+1);
    end
    if (!ph_a)
    begin
      l_cnt[0] = tmp_cnt[0];             // comparator 0 reused every later step
      l_sym[0] = tmp_sym[0];
      r_cnt[0] = tmp_cnt[1];
      r_sym[0] = tmp_sym[1];
      l_cnt[1] = ph_b ? tmp_cnt[2] : snap[8];
      l_sym[1] = ph_b ? tmp_sym[2] : sym_t'(8);
      r_cnt[1] = ph_b ? tmp_cnt[3] : snap[9];
      r_sym[1] = ph_b ? tmp_sym[3] : sym_t'(9);
    end
    for (int k = 0; k < 4; k++)
    begin
      w_cnt[k] = (r_cnt[k] <= l_cnt[k]) ? r_cnt[k] : l_cnt[k];  // tie to higher index
      w_sym[k] = (r_cnt[k] <= l_cnt[k]) ? r_sym[k] : l_sym[k];
    end
  end

  always_ff @(posedge clk)
  begin
    if (step.sel[0])
      snap <= counts;
    else if (step.sel[5])
      for (int i = 0; i < `HUFF_NUM_SYM; i++)
        snap[i] <= (sym_t'(i) == pair.sym_a) ? `HUFF_CNT_MAX : counts[i];  // hide winner
    if (ph_a)
      for (int k = 0; k < 4; k++)
      begin
        tmp_cnt[k] <= w_cnt[k];
        tmp_sym[k] <= w_sym[k];
      end
    else if (ph_b | ph_c)
    begin
      tmp_cnt[0] <= w_cnt[0];
      tmp_sym[0] <= w_sym[0];
      tmp_cnt[1] <= w_cnt[1];
      tmp_sym[1] <= w_sym[1];
    end
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      pair <= '0;
    else if (ph_d)
    begin
      if (step.sel[4])
        pair.sym_a <= w_sym[0];          // smallest
      else
        pair.sym_b <= w_sym[0];          // second smallest, ready for merge
    end
  end

endmodule

// File: source/code_builder.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module code_builder
  import huff_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        clear,
  input  logic        merge,
  input  logic        encode,
  input  merge_pair_t pair,
  output code_table_t code_table
);

  sym_mask_t masks [`HUFF_NUM_SYM];   // subtree held by each live slot
  sym_mask_t mask_a;                  // old subtree of the smaller side
  sym_mask_t mask_b;                  // old subtree of the larger side

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      for (int i = 0; i < `HUFF_NUM_SYM; i++)
        masks[i] <= sym_mask_t'(1) << i;
      mask_a     <= '0;
      mask_b     <= '0;
      code_table <= '0;
    end
    else if (clear)
    begin
      for (int i = 0; i < `HUFF_NUM_SYM; i++)
        masks[i] <= sym_mask_t'(1) << i;                      // every digit is a leaf
      mask_a     <= '0;
      mask_b     <= '0;
      code_table <= '0;
    end
    else if (merge)
    begin
      mask_a <= masks[pair.sym_a];
      mask_b <= masks[pair.sym_b];
      masks[pair.sym_b] <= masks[pair.sym_a] | masks[pair.sym_b];  // join subtrees
    end
    else if (encode)
    begin
      for (int i = 0; i < `HUFF_NUM_SYM; i++)
      begin
        if (mask_a[i] | mask_b[i])
        begin
          // new msb sits just above the current code
          if (mask_b[i])
            code_table[i].code[code_table[i].len] <= 1'b1;
          code_table[i].len <= code_table[i].len + 1'b1;
        end
      end
    end
  end

endmodule

// File: source/code_table_serializer.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module code_table_serializer
  import huff_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        emit_go,
  input  code_table_t code_table,
  output logic        table_start,
  output logic        table_valid,
  output logic        table_bit,
  output logic        table_done
);

  logic                   busy;       // table in flight
  sym_t                   dig;        // digit being sent
  logic [`HUFF_LEN_W-1:0] cnt;        // bits already sent for dig
  code_entry_t            cur;

  assign cur = (dig < `HUFF_NUM_SYM) ? code_table[dig] : '0;

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      busy        <= 1'b0;
      dig         <= '0;
      cnt         <= '0;
      table_start <= 1'b0;
      table_valid <= 1'b0;
      table_bit   <= 1'b0;
      table_done  <= 1'b0;
    end
    else
    begin
      table_start <= 1'b0;                                    // all flags are pulses
      table_valid <= 1'b0;
      table_bit   <= 1'b0;
      table_done  <= 1'b0;
      if (!busy)
      begin
        if (emit_go)
        begin
          busy        <= 1'b1;
          dig         <= '0;
          cnt         <= '0;
          table_start <= 1'b1;
        end
      end
      else if (dig == `HUFF_NUM_SYM)
      begin
        busy       <= 1'b0;
        table_done <= 1'b1;                                   // cycle after last bit
      end
      else if (cur.len == '0)
        dig <= dig + 1'b1;                                    // nothing to send
      else
      begin
        table_valid <= 1'b1;
        table_bit   <= cur.code[cur.len - 1'b1 - cnt];        // msb first
        if (cnt == cur.len - 1'b1)
        begin
          cnt <= '0;
          dig <= dig + 1'b1;
        end
        else
          cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// File: source/huff_top.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module huff_top
  import huff_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic sym_req,      // four-phase request
  input  sym_t sym,
  output logic sym_ack,
  output logic table_start,
  output logic table_valid,
  output logic table_bit,
  output logic table_done
);

  logic        count_inc;
  sym_t        count_sym;
  logic        clear;          // new block starts
  step_t       step;
  logic        emit_go;
  count_vec_t  counts;
  merge_pair_t pair;
  code_table_t code_table;

  huff_control u_control (
    .clk        (clk),
    .rst        (rst),
    .sym_req    (sym_req),
    .sym        (sym),
    .sym_ack    (sym_ack),
    .count_inc  (count_inc),
    .count_sym  (count_sym),
    .clear      (clear),
    .step       (step),
    .emit_go    (emit_go),
    .table_done (table_done)
  );

  symbol_counter u_counter (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .count_inc (count_inc),
    .count_sym (count_sym),
    .merge     (step.merge),
    .pair      (pair),
    .counts    (counts)
  );

  min_pair_select u_select (
    .clk    (clk),
    .rst    (rst),
    .step   (step),
    .counts (counts),
    .pair   (pair)
  );

  code_builder u_builder (
    .clk        (clk),
    .rst        (rst),
    .clear      (clear),
    .merge      (step.merge),
    .encode     (step.encode),
    .pair       (pair),
    .code_table (code_table)
  );

  code_table_serializer u_serializer (
    .clk         (clk),
    .rst         (rst),
    .emit_go     (emit_go),
    .code_table  (code_table),
    .table_start (table_start),
    .table_valid (table_valid),
    .table_bit   (table_bit),
    .table_done  (table_done)
  );

endmodule

// File: dv/huff_properties.sv
`timescale 1ns/1ns

module huff_properties
  import huff_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic sym_req,
  input sym_t sym,
  input logic sym_ack,
  input logic table_start,
  input logic table_valid,
  input logic table_done
);

  int   fail_cnt = 0;   // failed assertions so far
  logic in_table;       // between start and done pulses

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      in_table <= 1'b0;
    else if (table_start)
      in_table <= 1'b1;
    else if (table_done)
      in_table <= 1'b0;
  end

  // four-phase order
  ack_rise: assert property (@(posedge clk) disable iff (!rst) $rose(sym_ack) |-> sym_req)
    else
    begin
      $error("sym_ack rose without sym_req");
      fail_cnt++;
    end
  ack_fall: assert property (@(posedge clk) disable iff (!rst) $fell(sym_ack) |-> !sym_req)
    else
    begin
      $error("sym_ack fell while sym_req high");
      fail_cnt++;
    end
  req_hold: assert property (@(posedge clk) disable iff (!rst)
    sym_req && !sym_ack |=> sym_req)
    else
    begin
      $error("sym_req dropped before sym_ack");
      fail_cnt++;
    end
  sym_stable: assert property (@(posedge clk) disable iff (!rst)
    sym_req && $past(sym_req) |-> $stable(sym))
    else
    begin
      $error("sym changed while sym_req high");
      fail_cnt++;
    end
  valid_framed: assert property (@(posedge clk) disable iff (!rst)
    table_valid |-> in_table && !table_start && !table_done)
    else
    begin
      $error("table_valid outside the table frame");
      fail_cnt++;
    end
  pulse_len: assert property (@(posedge clk) disable iff (!rst)
    (table_start || table_done) |=> !(table_start || table_done))
    else
    begin
      $error("framing pulse longer than one cycle");
      fail_cnt++;
    end

endmodule

bind huff_top huff_properties u_props (
  .clk         (clk),
  .rst         (rst),
  .sym_req     (sym_req),
  .sym         (sym),
  .sym_ack     (sym_ack),
  .table_start (table_start),
  .table_valid (table_valid),
  .table_done  (table_done)
);

// File: dv/huff_tb.sv
`timescale 1ns/1ns
`include "huff_settings.svh"

module huff_tb
  import huff_pkg::*;
();

  localparam int SEED         = 32'h05fb_c7d0;
  localparam int BLOCK_WORDS  = 2 * `HUFF_NUM_SYM + 1;    // counts, invalid count, table
  localparam int STIM_WORDS   = 1 + 3 * BLOCK_WORDS;
  localparam int WAIT_LIMIT   = 1000;                      // covers a whole build and emit
  localparam int BUILD_CYCLES = 2 + `HUFF_ROUNDS * (`HUFF_NUM_SYM + 2);
  localparam sym_t BAD_SYM    = 4'hf;

  logic clk = 1'b0;
  logic rst;
  logic sym_req;
  sym_t sym;
  logic sym_ack;
  logic table_start;
  logic table_valid;
  logic table_bit;
  logic table_done;

  logic [15:0] stim_mem [STIM_WORDS];
  integer      seed;
  int          num_blocks;
  int          first_bit;
  int          value_errors = 0;
  int          timeout_errors = 0;
  int          cyc = 0;              // free running cycle count
  int          last_ack_cyc = 0;
  int          cur_bits = 0;
  logic        ack_prev = 1'b0;
  logic        valid_prev = 1'b0;    // table_valid one cycle back
  logic        bit_q [$];            // every serial table bit in order
  int          bit_cnt_q [$];        // bits per finished table
  int          delay_q [$];          // last ack to table_start, per table

  huff_top UUT (
    .clk         (clk),
    .rst         (rst),
    .sym_req     (sym_req),
    .sym         (sym),
    .sym_ack     (sym_ack),
    .table_start (table_start),
    .table_valid (table_valid),
    .table_bit   (table_bit),
    .table_done  (table_done)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  // outputs settle long before the falling edge
  always @(negedge clk)
  begin
    if (sym_ack && !ack_prev)
      last_ack_cyc = cyc;
    ack_prev = sym_ack;
    if (table_start)
    begin
      delay_q.push_back(cyc - last_ack_cyc);
      cur_bits = 0;
    end
    if (table_valid)
    begin
      bit_q.push_back(table_bit);
      cur_bits++;
    end
    if (table_done)
    begin
      bit_cnt_q.push_back(cur_bits);
      check_flag("table_done right after last bit", 1'b1, valid_prev);
    end
    valid_prev = table_valid;
  end

  task automatic finish_run();
    int assert_errors;
    assert_errors = UUT.u_props.fail_cnt;
    $display("errors: %0d value, %0d timeout, %0d assertion",
             value_errors, timeout_errors, assert_errors);
    if (value_errors + timeout_errors + assert_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  endtask

  task automatic report_timeout(input string why);
    $display("timeout: %s", why);
    timeout_errors++;
  endtask

  task automatic check_entry(input string name, input code_entry_t exp, input code_entry_t act);
    if (act !== exp)
    begin
      value_errors++;
      $display("FAILED %s: expected code %h len %0d, actual code %h len %0d",
               name, exp.code, exp.len, act.code, act.len);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      value_errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input count_t exp, input count_t act);
    if (act !== exp)
    begin
      value_errors++;
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic send_symbol(input sym_t s);
    int gap;
    int wait_cnt;
    gap = {$random(seed)} % 4;                               // random idle gap
    repeat (gap) @(posedge clk);
    wait_cnt = 0;
    @(negedge clk);
    while (sym_ack && wait_cnt < WAIT_LIMIT)                 // previous ack still up
    begin
      @(negedge clk);
      wait_cnt++;
    end
    if (sym_ack)
      report_timeout("sym_ack never fell after sym_req dropped");
    else
    begin
      @(posedge clk);
      sym     <= s;
      sym_req <= 1'b1;
      @(negedge clk);
      check_flag("ack waits for req", 1'b0, sym_ack);       // ack is a registered reply
      wait_cnt = 0;
      while (!sym_ack && wait_cnt < WAIT_LIMIT)
      begin
        @(negedge clk);
        wait_cnt++;
      end
      if (!sym_ack)
        report_timeout("no sym_ack for a pending sym_req");
      @(posedge clk);
      sym_req <= 1'b0;
    end
  endtask

  task automatic send_block(input int blk);
    int base;
    int left;
    int d;
    int rem [`HUFF_NUM_SYM + 1];
    base = 1 + blk * BLOCK_WORDS;
    left = 0;
    for (d = 0; d <= `HUFF_NUM_SYM; d++)
    begin
      rem[d] = stim_mem[base + d];
      left += rem[d];
    end
    while (left > 0 && timeout_errors == 0)                  // round robin over digits
      for (d = 0; d <= `HUFF_NUM_SYM; d++)
        if (rem[d] > 0 && timeout_errors == 0)
        begin
          send_symbol((d == `HUFF_NUM_SYM) ? BAD_SYM : sym_t'(d));
          rem[d]--;
          left--;
        end
  endtask

  task automatic wait_tables(input int n);
    int wait_cnt;
    wait_cnt = 0;
    while (bit_cnt_q.size() < n && wait_cnt < WAIT_LIMIT)
    begin
      @(posedge clk);
      wait_cnt++;
    end
    if (bit_cnt_q.size() < n)
      report_timeout("code table never finished");
  endtask

  // cut the serial stream by the expected lengths
  task automatic check_table(input int blk, input int start);
    int          base;
    int          pos;
    int          exp_sum;
    int          d;
    int          k;
    code_entry_t exp_e;
    code_entry_t got_e;
    base    = 1 + blk * BLOCK_WORDS + `HUFF_NUM_SYM + 1;
    pos     = start;
    exp_sum = 0;
    for (d = 0; d < `HUFF_NUM_SYM; d++)
    begin
      exp_e = code_entry_t'(stim_mem[base + d][12:0]);
      got_e = '0;
      for (k = 0; k < exp_e.len; k++)
        if (pos < start + bit_cnt_q[blk])                    // short table leaves len short
        begin
          got_e.code = {got_e.code[`HUFF_CODE_W-2:0], bit_q[pos]};  // msb arrives first
          got_e.len  = got_e.len + 1'b1;
          pos++;
        end
      exp_sum += exp_e.len;
      check_entry($sformatf("block %0d digit %0d", blk, d), exp_e, got_e);
    end
    check_count($sformatf("block %0d bit count", blk), count_t'(exp_sum),
                count_t'(bit_cnt_q[blk]));
    check_count($sformatf("block %0d start delay", blk), count_t'(BUILD_CYCLES),
                count_t'(delay_q[blk]));
  endtask

  initial
  begin
    rst     <= 1'b0;
    sym_req <= 1'b0;
    sym     <= '0;
    seed = SEED;
    $readmemh("dv/huff_stimulus.txt", stim_mem);
    num_blocks = stim_mem[0];
    repeat (16) @(posedge clk);
    rst <= 1'b1;
    repeat (3) @(negedge clk);
    check_flag("reset sym_ack", 1'b0, sym_ack);
    check_flag("reset table_start", 1'b0, table_start);
    check_flag("reset table_valid", 1'b0, table_valid);
    check_flag("reset table_bit", 1'b0, table_bit);
    check_flag("reset table_done", 1'b0, table_done);
    for (int b = 0; b < num_blocks; b++)
      if (timeout_errors == 0)
        send_block(b);                                       // blocks back to back
    if (timeout_errors == 0)
      wait_tables(num_blocks);
    if (timeout_errors == 0)
    begin
      first_bit = 0;
      for (int b = 0; b < num_blocks; b++)
      begin
        check_table(b, first_bit);
        first_bit += bit_cnt_q[b];
      end
    end
    finish_run();
  end

endmodule

// File: flist.f
+incdir+source
source/huff_pkg.sv
source/huff_control.sv
source/symbol_counter.sv
source/min_pair_select.sv
source/code_builder.sv
source/code_table_serializer.sv
source/huff_top.sv
dv/huff_properties.sv
dv/huff_tb.sv

// File: Bender.yml
package:
  name: huff_coder

sources:
  - include_dirs:
      - source
    files:
      - source/huff_pkg.sv
      - source/huff_control.sv
      - source/symbol_counter.sv
      - source/min_pair_select.sv
      - source/code_builder.sv
      - source/code_table_serializer.sv
      - source/huff_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/huff_properties.sv
      - dv/huff_tb.sv

// File: dv/huff_stimulus.txt
// huffman block stimulus, all values hex
// first word is the number of blocks
// per block, first line: symbol counts for digits 0..9, then count of symbol f (ignored)
// per block, second line: expected {code[8:0], len[3:0]} for digits 0..9
003
// distinct counts plus two invalid symbols
028 003 019 007 03c 00c 001 01e 032 01a 002
063 717 0f4 396 022 1d5 707 033 002 023
// 256 copies of digit 3, degenerate tree
000 000 000 100 000 000 000 000 000 000 000
012 013 014 011 015 016 017 018 019 009
// all digits tied at 25, six invalid symbols
019 019 019 019 019 019 019 019 019 019 006
053 043 033 023 013 003 0f4 0e4 0d4 0c4
